/* verilog/ipu_bus_pkg.sv */
// Accelerator bus widths
// Request and response payload structs

package ipu_bus_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 5;

  // Offloaded instruction with its single argument
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data_op;
    logic [DATA_W-1:0] data_arga;
  } acc_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              error;
  } acc_resp_t;

endpackage

/* verilog/ipu_isa_pkg.sv */
// IPU instruction fields, opcodes and function codes
// ALU operation and operand-select enums, decoded-instruction struct

package ipu_isa_pkg;

  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // ---------------------------------------------------------------------
  // Instruction word fields
  // ---------------------------------------------------------------------
  localparam int unsigned OPC_LO    = 0;
  localparam int unsigned OPC_W     = 7;
  localparam int unsigned RD_LO     = 7;
  localparam int unsigned FUNCT3_LO = 12;
  localparam int unsigned FUNCT3_W  = 3;
  localparam int unsigned RS1_LO    = 15;
  localparam int unsigned RS2_LO    = 20;
  localparam int unsigned FUNCT7_LO = 25;
  localparam int unsigned FUNCT7_W  = 7;
  localparam int unsigned IMM_LO    = 20;
  localparam int unsigned IMM_W     = 12;
  localparam int unsigned SHAMT_W   = 5;

  // Major opcodes
  localparam logic [OPC_W-1:0] OPC_IPU_IMM = 7'h0b;
  localparam logic [OPC_W-1:0] OPC_IPU_REG = 7'h2b;
  localparam logic [OPC_W-1:0] OPC_IPU_MV  = 7'h5b;

  // Operation funct3 codes
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'd0;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'd1;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'd2;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'd3;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'd4;
  localparam logic [FUNCT3_W-1:0] F3_SR   = 3'd5;
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'd6;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'd7;

  // Selects sub and sra
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT = 7'h20;

  // Move funct3 codes
  localparam logic [FUNCT3_W-1:0] MV_W_X = 3'd0;
  localparam logic [FUNCT3_W-1:0] MV_X_W = 3'd1;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_A
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_REG, OP_IMM, OP_ARGA
  } op_sel_e;

  typedef struct packed {
    alu_op_e                           alu_op;
    op_sel_e                           a_sel;
    op_sel_e                           b_sel;
    logic [REG_ADDR_W-1:0]             rd;
    logic [REG_ADDR_W-1:0]             rs1;
    logic [REG_ADDR_W-1:0]             rs2;
    logic [ipu_bus_pkg::DATA_W-1:0]    imm;
    logic                              writes_rf;
    logic                              responds;
    logic                              illegal;
  } ipu_dec_t;

endpackage

/* verilog/ipu_spill_reg.sv */
// Two-entry valid/ready spill register, payload type given by parameter

`timescale 1ns/100ps

module ipu_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic a_full_q, b_full_q;
  logic a_fill, a_drain;
  logic b_fill, b_drain;
  T     a_data_q, b_data_q;

  // ---------------------------------------------------------------------
  // Slot A takes new data, slot B holds the older item on a stall
  // ---------------------------------------------------------------------
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Not full means at least one slot free
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

/* verilog/ipu_decoder.sv */
// IPU instruction decoder
// Checks opcode, funct3 and funct7 and fills the decoded-instruction struct

`timescale 1ns/100ps

module ipu_decoder (
  input  logic [ipu_bus_pkg::DATA_W-1:0] instr_i,
  output ipu_isa_pkg::ipu_dec_t          dec_o
);

  logic [ipu_isa_pkg::OPC_W-1:0]    opcode;
  logic [ipu_isa_pkg::FUNCT3_W-1:0] funct3;
  logic [ipu_isa_pkg::FUNCT7_W-1:0] funct7;
  logic                             is_imm;
  logic                             f7_zero;
  logic                             f7_alt;
  logic                             bad;

  assign opcode  = instr_i[ipu_isa_pkg::OPC_LO +: ipu_isa_pkg::OPC_W];
  assign funct3  = instr_i[ipu_isa_pkg::FUNCT3_LO +: ipu_isa_pkg::FUNCT3_W];
  assign funct7  = instr_i[ipu_isa_pkg::FUNCT7_LO +: ipu_isa_pkg::FUNCT7_W];
  assign is_imm  = (opcode == ipu_isa_pkg::OPC_IPU_IMM);
  assign f7_zero = (funct7 == '0);
  assign f7_alt  = (funct7 == ipu_isa_pkg::FUNCT7_ALT);

  always_comb begin
    dec_o.alu_op    = ipu_isa_pkg::ALU_ADD;
    dec_o.a_sel     = ipu_isa_pkg::OP_REG;
    dec_o.b_sel     = ipu_isa_pkg::OP_REG;
    dec_o.rd        = instr_i[ipu_isa_pkg::RD_LO +: ipu_isa_pkg::REG_ADDR_W];
    dec_o.rs1       = instr_i[ipu_isa_pkg::RS1_LO +: ipu_isa_pkg::REG_ADDR_W];
    dec_o.rs2       = instr_i[ipu_isa_pkg::RS2_LO +: ipu_isa_pkg::REG_ADDR_W];
    dec_o.imm       = {{(ipu_bus_pkg::DATA_W - ipu_isa_pkg::IMM_W){instr_i[31]}},
                       instr_i[ipu_isa_pkg::IMM_LO +: ipu_isa_pkg::IMM_W]};
    dec_o.writes_rf = 1'b0;
    dec_o.responds  = 1'b0;
    dec_o.illegal   = 1'b0;
    bad             = 1'b0;

    case (opcode)
      ipu_isa_pkg::OPC_IPU_IMM, ipu_isa_pkg::OPC_IPU_REG: begin
        dec_o.writes_rf = 1'b1;
        if (is_imm) begin
          dec_o.b_sel = ipu_isa_pkg::OP_IMM;
        end
        // Upper immediate bits only matter for shifts
        bad = ~is_imm & ~f7_zero;
        case (funct3)
          ipu_isa_pkg::F3_ADD: begin
            dec_o.alu_op = (~is_imm & f7_alt) ? ipu_isa_pkg::ALU_SUB : ipu_isa_pkg::ALU_ADD;
            bad = ~is_imm & ~f7_zero & ~f7_alt;
          end
          ipu_isa_pkg::F3_SLL: begin
            dec_o.alu_op = ipu_isa_pkg::ALU_SLL;
            bad = ~f7_zero;
          end
          ipu_isa_pkg::F3_SLT:  dec_o.alu_op = ipu_isa_pkg::ALU_SLT;
          ipu_isa_pkg::F3_SLTU: dec_o.alu_op = ipu_isa_pkg::ALU_SLTU;
          ipu_isa_pkg::F3_XOR:  dec_o.alu_op = ipu_isa_pkg::ALU_XOR;
          ipu_isa_pkg::F3_SR: begin
            dec_o.alu_op = f7_alt ? ipu_isa_pkg::ALU_SRA : ipu_isa_pkg::ALU_SRL;
            bad = ~f7_zero & ~f7_alt;
          end
          ipu_isa_pkg::F3_OR:   dec_o.alu_op = ipu_isa_pkg::ALU_OR;
          ipu_isa_pkg::F3_AND:  dec_o.alu_op = ipu_isa_pkg::ALU_AND;
        endcase
      end
      ipu_isa_pkg::OPC_IPU_MV: begin
        dec_o.alu_op = ipu_isa_pkg::ALU_PASS_A;
        if (funct3 == ipu_isa_pkg::MV_W_X) begin
          dec_o.a_sel     = ipu_isa_pkg::OP_ARGA;
          dec_o.writes_rf = 1'b1;
        end else if (funct3 == ipu_isa_pkg::MV_X_W) begin
          dec_o.responds = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase

    // Illegal encodings answer with an error and write nothing
    if (bad) begin
      dec_o.illegal   = 1'b1;
      dec_o.writes_rf = 1'b0;
      dec_o.responds  = 1'b1;
    end
  end

endmodule

/* verilog/ipu_alu.sv */
// Combinational 32-bit integer ALU

`timescale 1ns/100ps

module ipu_alu (
  input  ipu_isa_pkg::alu_op_e           op_i,
  input  logic [ipu_bus_pkg::DATA_W-1:0] a_i,
  input  logic [ipu_bus_pkg::DATA_W-1:0] b_i,
  output logic [ipu_bus_pkg::DATA_W-1:0] result_o
);

  logic [ipu_isa_pkg::SHAMT_W-1:0] shamt;
  logic                            lt_signed;
  logic                            lt_unsigned;

  assign shamt       = b_i[ipu_isa_pkg::SHAMT_W-1:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ipu_isa_pkg::ALU_ADD:    result_o = a_i + b_i;
      ipu_isa_pkg::ALU_SUB:    result_o = a_i - b_i;
      ipu_isa_pkg::ALU_SLL:    result_o = a_i << shamt;
      ipu_isa_pkg::ALU_SLT: begin
        result_o = {{(ipu_bus_pkg::DATA_W-1){1'b0}}, lt_signed};
      end
      ipu_isa_pkg::ALU_SLTU: begin
        result_o = {{(ipu_bus_pkg::DATA_W-1){1'b0}}, lt_unsigned};
      end
      ipu_isa_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      ipu_isa_pkg::ALU_SRL:    result_o = a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ipu_isa_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ipu_isa_pkg::ALU_OR:     result_o = a_i | b_i;
      ipu_isa_pkg::ALU_AND:    result_o = a_i & b_i;
      ipu_isa_pkg::ALU_PASS_A: result_o = a_i;
      default:                 result_o = '0;
    endcase
  end

endmodule

/* verilog/ipu_regfile.sv */
// 32x32 integer register file, two read ports, one write port

`timescale 1ns/100ps

module ipu_regfile (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [ipu_isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [ipu_isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [ipu_bus_pkg::DATA_W-1:0]     rdata_a_o,
  output logic [ipu_bus_pkg::DATA_W-1:0]     rdata_b_o,
  input  logic                              we_i,
  input  logic [ipu_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [ipu_bus_pkg::DATA_W-1:0]     wdata_i
);

  logic [ipu_bus_pkg::DATA_W-1:0] regs_q [ipu_isa_pkg::NUM_REGS];

  // Register 0 is writable like all others
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ipu_isa_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* verilog/ipu_exec.sv */
// IPU processing stage
// Decode, register read, ALU, write-back and response forming

`timescale 1ns/100ps

module ipu_exec (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ipu_bus_pkg::acc_req_t  req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output ipu_bus_pkg::acc_resp_t resp_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i
);

  ipu_isa_pkg::ipu_dec_t          dec;
  logic [ipu_bus_pkg::DATA_W-1:0] rdata_a, rdata_b;
  logic [ipu_bus_pkg::DATA_W-1:0] op_a, op_b;
  logic [ipu_bus_pkg::DATA_W-1:0] alu_result;
  logic                           rf_we;

  ipu_decoder i_decoder (
    .instr_i ( req_i.data_op ),
    .dec_o   ( dec           )
  );

  // ---------------------------------------------------------------------
  // Operand select
  // ---------------------------------------------------------------------
  assign op_a = (dec.a_sel == ipu_isa_pkg::OP_ARGA) ? req_i.data_arga : rdata_a;
  assign op_b = (dec.b_sel == ipu_isa_pkg::OP_IMM) ? dec.imm : rdata_b;

  ipu_alu i_alu (
    .op_i     ( dec.alu_op ),
    .a_i      ( op_a       ),
    .b_i      ( op_b       ),
    .result_o ( alu_result )
  );

  // ---------------------------------------------------------------------
  // Handshake and write-back
  // ---------------------------------------------------------------------
  assign resp_valid_o = req_valid_i & dec.responds;
  // Stall only while a response is refused
  assign req_ready_o  = ~(resp_valid_o & ~resp_ready_i);
  assign rf_we        = req_valid_i & req_ready_o & dec.writes_rf;

  ipu_regfile i_regfile (
    .clk_i,
    .rst_n_i,
    .raddr_a_i ( dec.rs1    ),
    .raddr_b_i ( dec.rs2    ),
    .rdata_a_o ( rdata_a    ),
    .rdata_b_o ( rdata_b    ),
    .we_i      ( rf_we      ),
    .waddr_i   ( dec.rd     ),
    .wdata_i   ( alu_result )
  );

  assign resp_o.id    = req_i.id;
  assign resp_o.data  = dec.illegal ? '0 : alu_result;
  assign resp_o.error = dec.illegal;

endmodule

/* verilog/ipu_int_ss.sv */
// Integer processing unit top level
// Request spill register, processing stage, response spill register

`timescale 1ns/100ps

module ipu_int_ss (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ipu_bus_pkg::acc_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output ipu_bus_pkg::acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  ipu_bus_pkg::acc_req_t  req_q;
  logic                   req_valid_q, req_ready_q;
  ipu_bus_pkg::acc_resp_t resp;
  logic                   resp_valid, resp_ready;

  // ---------------------------------------------------------------------
  // Request side
  // ---------------------------------------------------------------------
  ipu_spill_reg #(
    .T ( ipu_bus_pkg::acc_req_t )
  ) i_req_spill (
    .clk_i,
    .rst_n_i,
    .valid_i ( acc_req_valid_i ),
    .ready_o ( acc_req_ready_o ),
    .data_i  ( acc_req_i       ),
    .valid_o ( req_valid_q     ),
    .ready_i ( req_ready_q     ),
    .data_o  ( req_q           )
  );

  ipu_exec i_exec (
    .clk_i,
    .rst_n_i,
    .req_i        ( req_q       ),
    .req_valid_i  ( req_valid_q ),
    .req_ready_o  ( req_ready_q ),
    .resp_o       ( resp        ),
    .resp_valid_o ( resp_valid  ),
    .resp_ready_i ( resp_ready  )
  );

  // ---------------------------------------------------------------------
  // Response side
  // ---------------------------------------------------------------------
  ipu_spill_reg #(
    .T ( ipu_bus_pkg::acc_resp_t )
  ) i_resp_spill (
    .clk_i,
    .rst_n_i,
    .valid_i ( resp_valid       ),
    .ready_o ( resp_ready       ),
    .data_i  ( resp             ),
    .valid_o ( acc_resp_valid_o ),
    .ready_i ( acc_resp_ready_i ),
    .data_o  ( acc_resp_o       )
  );

endmodule

/* testbench/ipu_model.svh */
// Reference model of the IPU register file and instruction rules
// Included inside the testbench module

`ifndef IPU_MODEL_SVH
`define IPU_MODEL_SVH

logic [ipu_bus_pkg::DATA_W-1:0] ref_regs [ipu_isa_pkg::NUM_REGS];

// Applies one accepted request and returns the response it must produce
task automatic apply_instr(input  ipu_bus_pkg::acc_req_t  req,
                           output logic                   responds,
                           output ipu_bus_pkg::acc_resp_t resp);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [4:0]  rd;
  logic [31:0] a, b, res;
  logic        is_reg, illegal, wr;
  opc      = req.data_op[6:0];
  f3       = req.data_op[14:12];
  f7       = req.data_op[31:25];
  rd       = req.data_op[11:7];
  is_reg   = (opc == ipu_isa_pkg::OPC_IPU_REG);
  a        = ref_regs[req.data_op[19:15]];
  b        = is_reg ? ref_regs[req.data_op[24:20]] : {{20{req.data_op[31]}}, req.data_op[31:20]};
  illegal  = 1'b0;
  wr       = 1'b0;
  responds = 1'b0;
  res      = '0;
  case (opc)
    ipu_isa_pkg::OPC_IPU_IMM, ipu_isa_pkg::OPC_IPU_REG: begin
      wr = 1'b1;
      case (f3)
        3'd0: begin
          if (is_reg && f7 == 7'h20) begin
            res = a - b;
          end else begin
            res = a + b;
            illegal = is_reg && (f7 != 7'h00);
          end
        end
        3'd1: begin
          res = a << b[4:0];
          illegal = (f7 != 7'h00);
        end
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          if (f7 == 7'h20) begin
            res = $signed(a) >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
          illegal = (f7 != 7'h00) && (f7 != 7'h20);
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
      // Register form wants zero funct7 apart from sub and sra
      if (is_reg && f3 != 3'd0 && f3 != 3'd5 && f7 != 7'h00) begin
        illegal = 1'b1;
      end
    end
    ipu_isa_pkg::OPC_IPU_MV: begin
      if (f3 == 3'd0) begin
        wr  = 1'b1;
        res = req.data_arga;
      end else if (f3 == 3'd1) begin
        responds = 1'b1;
        res      = a;
      end else begin
        illegal = 1'b1;
      end
    end
    default: illegal = 1'b1;
  endcase
  if (illegal) begin
    wr       = 1'b0;
    responds = 1'b1;
    res      = '0;
  end
  if (wr) begin
    ref_regs[rd] = res;
  end
  resp.id    = req.id;
  resp.data  = res;
  resp.error = illegal;
endtask

`endif

/* testbench/tb_ipu_int_ss.sv */
// Testbench for the IPU top level
// Random instruction stream, back-pressure, model checker and watchdog

`timescale 1ns/100ps

module tb_ipu_int_ss;

  localparam int          CLK_PERIOD    = 4;
  localparam int          N_RESET_READS = 8;
  localparam int          N_RANDOM      = 2000;
  localparam int          N_TOTAL       = N_RESET_READS + ipu_isa_pkg::NUM_REGS + N_RANDOM;
  localparam logic [31:0] SEED          = 32'hc164;

  logic                   clk_i;
  logic                   rst_n_i;
  ipu_bus_pkg::acc_req_t  acc_req_i;
  logic                   acc_req_valid_i;
  logic                   acc_req_ready_o;
  ipu_bus_pkg::acc_resp_t acc_resp_o;
  logic                   acc_resp_valid_o;
  logic                   acc_resp_ready_i;

  ipu_bus_pkg::acc_resp_t exp_q [$];
  logic [31:0]            stim_state = SEED;
  logic [31:0]            bp_state   = SEED;
  logic [4:0]             id_cnt     = '0;
  logic                   bp_en      = 1'b0;
  logic                   lat_mode   = 1'b0;
  logic                   lat_pending = 1'b0;
  int                     lat_edge;
  int                     cyc = 0;
  int                     errors = 0;
  int                     n_resp = 0;
  int                     n_illegal = 0;
  int                     stall_cycles = 0;

  `include "ipu_model.svh"

  ipu_int_ss ipu_int_ss_i (
    .clk_i,
    .rst_n_i,
    .acc_req_i,
    .acc_req_valid_i,
    .acc_req_ready_o,
    .acc_resp_o,
    .acc_resp_valid_o,
    .acc_resp_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // ---------------------------------------------------------------------
  // Random numbers and instruction words
  // ---------------------------------------------------------------------
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Joins the upper halves of two LCG steps
  function automatic logic [31:0] next_rand();
    logic [31:0] hi;
    stim_state = lcg(stim_state);
    hi         = stim_state;
    stim_state = lcg(stim_state);
    return {hi[31:16], stim_state[31:16]};
  endfunction

  function automatic logic [31:0] random_instr(input logic bad);
    logic [31:0] r;
    logic [31:0] w;
    r = next_rand();
    w = next_rand();
    if (bad) begin
      case (r[1:0])
        2'd0: begin
          w[6:0] = r[8:2];
          if (w[6:0] == 7'h0b || w[6:0] == 7'h2b || w[6:0] == 7'h5b) begin
            w[6:0] = w[6:0] ^ 7'h40;
          end
        end
        2'd1: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_MV;
          w[14:12] = 3'd2 + 3'(r[4:2] % 6);
        end
        2'd2: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_REG;
          w[31:25] = r[8:2] | 7'h01;
        end
        default: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_IMM;
          w[14:12] = r[2] ? 3'd5 : 3'd1;
          w[31:25] = r[9:3] | 7'h01;
        end
      endcase
    end else begin
      case (r[1:0])
        2'd0: begin
          w[6:0] = ipu_isa_pkg::OPC_IPU_IMM;
          if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
            w[31:25] = (r[2] && w[14:12] == 3'd5) ? 7'h20 : 7'h00;
          end
        end
        2'd1: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_REG;
          w[31:25] = (r[2] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
        end
        2'd2: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_MV;
          w[14:12] = ipu_isa_pkg::MV_W_X;
        end
        default: begin
          w[6:0]   = ipu_isa_pkg::OPC_IPU_MV;
          w[14:12] = ipu_isa_pkg::MV_X_W;
        end
      endcase
    end
    return w;
  endfunction

  // Called just after a rising edge and returns just after the transfer edge
  task automatic send_word(input logic [31:0] word, input logic [31:0] arga);
    ipu_bus_pkg::acc_req_t req;
    req.id          = id_cnt;
    req.data_op     = word;
    req.data_arga   = arga;
    id_cnt          = id_cnt + 5'd1;
    acc_req_i       <= req;
    acc_req_valid_i <= 1'b1;
    do @(negedge clk_i); while (!acc_req_ready_o);
    @(posedge clk_i);
    acc_req_valid_i <= 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  task automatic check_resp(input ipu_bus_pkg::acc_resp_t got,
                            input ipu_bus_pkg::acc_resp_t exp);
    if (got !== exp) begin
      $display("error acc_resp_o: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("error acc_resp_valid_o latency: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  // Random toggling keeps the response side stalled for several cycles
  always @(posedge clk_i) begin
    bp_state = lcg(bp_state);
    if (!bp_en) begin
      acc_resp_ready_i <= 1'b1;
    end else if (bp_state[31:29] == 3'd0) begin
      acc_resp_ready_i <= ~acc_resp_ready_i;
    end
  end

  // Sampled mid-cycle where values hold until the next rising edge
  always @(negedge clk_i) begin : monitor
    ipu_bus_pkg::acc_resp_t exp;
    logic                   responds;
    if (rst_n_i) begin
      if (acc_resp_valid_o && acc_resp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("response with id %h arrived while none was outstanding", acc_resp_o.id);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_resp(acc_resp_o, exp);
          n_resp++;
        end
        if (lat_pending) begin
          check_latency(cyc + 1 - lat_edge, 2);
          lat_pending = 1'b0;
        end
      end
      if (acc_req_valid_i && acc_req_ready_o) begin
        apply_instr(acc_req_i, responds, exp);
        if (responds) begin
          exp_q.push_back(exp);
          if (lat_mode) begin
            lat_pending = 1'b1;
            lat_edge    = cyc + 1;
          end
        end
      end
      if (!acc_req_ready_o) begin
        stall_cycles++;
      end
    end
  end

  initial begin
    #(N_TOTAL * 40 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with %0d responses outstanding",
             cyc, exp_q.size());
    $display("FAIL: see errors above");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin : main
    logic [31:0] w;
    logic [31:0] r;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    rst_n_i          = 1'b0;
    for (int i = 0; i < ipu_isa_pkg::NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_flag("acc_resp_valid_o", acc_resp_valid_o, 1'b0);
    check_flag("acc_req_ready_o", acc_req_ready_o, 1'b1);
    @(posedge clk_i);

    // Reset values read one request at a time for the latency check
    lat_mode = 1'b1;
    for (int i = 0; i < N_RESET_READS; i++) begin
      w = next_rand();
      w[6:0]   = ipu_isa_pkg::OPC_IPU_MV;
      w[14:12] = ipu_isa_pkg::MV_X_W;
      send_word(w, next_rand());
      while (exp_q.size() != 0) @(posedge clk_i);
      @(posedge clk_i);
    end
    lat_mode = 1'b0;

    for (int i = 0; i < ipu_isa_pkg::NUM_REGS; i++) begin
      w = next_rand();
      w[6:0]   = ipu_isa_pkg::OPC_IPU_MV;
      w[14:12] = ipu_isa_pkg::MV_W_X;
      w[11:7]  = 5'(i);
      send_word(w, next_rand());
    end

    @(negedge clk_i);
    bp_en = 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < N_RANDOM; i++) begin
      r = next_rand();
      if (r[31:28] == 4'd0) begin
        n_illegal++;
      end
      send_word(random_instr(r[31:28] == 4'd0), next_rand());
      if (r[27:26] == 2'd0) begin
        @(posedge clk_i);
      end
    end
    @(negedge clk_i);
    bp_en = 1'b0;
    @(posedge clk_i);

    for (int i = 0; i < 100 && exp_q.size() != 0; i++) begin
      @(posedge clk_i);
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      errors++;
    end
    if (stall_cycles == 0) begin
      $display("back-pressure never stalled the request side");
      errors++;
    end
    $display("responses %0d, illegal %0d, stall cycles %0d, errors %0d",
             n_resp, n_illegal, stall_cycles, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+testbench
verilog/ipu_bus_pkg.sv
verilog/ipu_isa_pkg.sv
verilog/ipu_spill_reg.sv
verilog/ipu_decoder.sv
verilog/ipu_alu.sv
verilog/ipu_regfile.sv
verilog/ipu_exec.sv
verilog/ipu_int_ss.sv
testbench/tb_ipu_int_ss.sv

/* Bender.yml */
package:
  name: ipu_int_ss

sources:
  - verilog/ipu_bus_pkg.sv
  - verilog/ipu_isa_pkg.sv
  - verilog/ipu_spill_reg.sv
  - verilog/ipu_decoder.sv
  - verilog/ipu_alu.sv
  - verilog/ipu_regfile.sv
  - verilog/ipu_exec.sv
  - verilog/ipu_int_ss.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ipu_int_ss.sv
